// File: pipe_core.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/control_decode.sv
source/reg_file.sv
source/decode.sv
source/execute.sv
source/result.sv
source/pipe_core.sv
testbench/tb_pipe_core.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pipe_core -f pipe_core.f

output=$(./obj_dir/Vtb_pipe_core)
echo "$output"

if echo "$output" | grep -qx "Regression passed"; then
   exit 0
else
   exit 1
fi

// File: source/control_decode.sv
// =========================================================================
// control block
//   opcode and funct to ALU operation, write enable, immediate handling,
//   branch and jump flags and destination field select
//   unknown opcodes are flagged illegal and never write
// =========================================================================
`timescale 1ns/1ps
`include "core_config.svh"

module control_decode (
   input  logic [`CORE_INST_W-1:0] inst,
   output isa_pkg::alu_op_e        alu_op,
   output logic                    reg_write,
   output logic                    imm_signed,
   output logic                    is_branch,
   output logic                    is_jal,
   output logic                    use_imm,
   output logic                    dest_sel,
   output logic                    illegal
);

   isa_pkg::r_fmt_t fmt;

   assign fmt = inst;

   always_comb begin
      alu_op     = isa_pkg::ALU_PASS_B;
      reg_write  = 1'b0;
      imm_signed = 1'b0;
      is_branch  = 1'b0;
      is_jal     = 1'b0;
      use_imm    = 1'b0;
      dest_sel   = 1'b0;
      illegal    = 1'b0;
      case (fmt.op)
         isa_pkg::OP_ALU: begin
            reg_write = 1'b1;
            // rd names the destination
            dest_sel  = 1'b1;
            case (fmt.funct)
               isa_pkg::FN_ADD: alu_op = isa_pkg::ALU_ADD;
               isa_pkg::FN_SUB: alu_op = isa_pkg::ALU_SUB;
               isa_pkg::FN_XOR: alu_op = isa_pkg::ALU_XOR;
               default:         alu_op = isa_pkg::ALU_AND;
            endcase
         end
         isa_pkg::OP_ADDI: begin
            reg_write  = 1'b1;
            use_imm    = 1'b1;
            imm_signed = 1'b1;
            alu_op     = isa_pkg::ALU_ADD;
         end
         isa_pkg::OP_XORI: begin
            reg_write = 1'b1;
            use_imm   = 1'b1;
            alu_op    = isa_pkg::ALU_XOR;
         end
         isa_pkg::OP_LBI: begin
            reg_write  = 1'b1;
            use_imm    = 1'b1;
            imm_signed = 1'b1;
         end
         isa_pkg::OP_BEQZ: begin
            is_branch  = 1'b1;
            imm_signed = 1'b1;
         end
         isa_pkg::OP_JAL: begin
            is_jal     = 1'b1;
            reg_write  = 1'b1;
            imm_signed = 1'b1;
         end
         isa_pkg::OP_NOP: ;
         default: illegal = 1'b1;
      endcase
   end

endmodule

// File: source/core_config.svh
// =========================================================================
// core width and register-number definitions
//   data and pc width, instruction width, register index width and the
//   link register used by JAL
// =========================================================================
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path and pc share one width
`define CORE_DATA_W 16
`define CORE_INST_W 16

// eight architectural registers
`define CORE_REG_ADDR_W 3

// JAL writes its return address here
`define CORE_LINK_REG 3'd7

`endif

// File: source/decode.sv
// =========================================================================
// decode stage
//   field split, control block, immediate extension, register read,
//   operand select, destination select and hazard stall
// =========================================================================
`timescale 1ns/1ps
`include "core_config.svh"

module decode (
   input  pipe_pkg::fetch_packet_t     fetch,
   input  logic [`CORE_REG_ADDR_W-1:0] exec_dest,
   input  logic                        exec_busy,
   input  logic [`CORE_REG_ADDR_W-1:0] result_dest,
   input  logic                        result_busy,
   output logic [`CORE_REG_ADDR_W-1:0] read_addr_a,
   output logic [`CORE_REG_ADDR_W-1:0] read_addr_b,
   input  logic [`CORE_DATA_W-1:0]     read_data_a,
   input  logic [`CORE_DATA_W-1:0]     read_data_b,
   output logic                        stall,
   output pipe_pkg::decode_packet_t    decoded
);

   isa_pkg::r_fmt_t             r_fmt;
   isa_pkg::i5_fmt_t            i5_fmt;
   isa_pkg::i8_fmt_t            i8_fmt;
   isa_pkg::j_fmt_t             j_fmt;
   isa_pkg::alu_op_e            alu_op;
   logic                        reg_write, imm_signed, is_branch, is_jal;
   logic                        use_imm, dest_sel, illegal;
   logic                        uses_rs, uses_rt, rs_hazard, rt_hazard;
   logic [`CORE_DATA_W-1:0]     imm;
   logic [`CORE_REG_ADDR_W-1:0] dest;

   assign r_fmt  = fetch.inst;
   assign i5_fmt = fetch.inst;
   assign i8_fmt = fetch.inst;
   assign j_fmt  = fetch.inst;

   control_decode ctrl (
      .inst       (fetch.inst),
      .alu_op     (alu_op),
      .reg_write  (reg_write),
      .imm_signed (imm_signed),
      .is_branch  (is_branch),
      .is_jal     (is_jal),
      .use_imm    (use_imm),
      .dest_sel   (dest_sel),
      .illegal    (illegal)
   );

   // immediate width and the sources actually read depend on the format
   always_comb begin
      uses_rs = 1'b0;
      uses_rt = 1'b0;
      imm     = '0;
      case (r_fmt.op)
         isa_pkg::OP_ALU: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
         end
         isa_pkg::OP_ADDI, isa_pkg::OP_XORI: begin
            uses_rs = 1'b1;
            imm = {{(`CORE_DATA_W-5){imm_signed & i5_fmt.imm5[4]}}, i5_fmt.imm5};
         end
         isa_pkg::OP_LBI:
            imm = {{(`CORE_DATA_W-8){imm_signed & i8_fmt.imm8[7]}}, i8_fmt.imm8};
         isa_pkg::OP_BEQZ: begin
            uses_rs = 1'b1;
            imm = {{(`CORE_DATA_W-8){imm_signed & i8_fmt.imm8[7]}}, i8_fmt.imm8};
         end
         isa_pkg::OP_JAL:
            imm = {{(`CORE_DATA_W-11){imm_signed & j_fmt.imm11[10]}}, j_fmt.imm11};
         default: ;
      endcase
   end

   always_comb begin
      if (is_jal)
         dest = `CORE_LINK_REG;
      else if (r_fmt.op == isa_pkg::OP_LBI)
         dest = i8_fmt.rs;
      else if (dest_sel)
         dest = r_fmt.rd;
      else
         dest = i5_fmt.rt;
   end

   assign read_addr_a = r_fmt.rs;
   assign read_addr_b = r_fmt.rt;

   // without forwarding a source waits until its producer has left result
   assign rs_hazard = uses_rs && ((exec_busy && exec_dest == r_fmt.rs) ||
                                  (result_busy && result_dest == r_fmt.rs));
   assign rt_hazard = uses_rt && ((exec_busy && exec_dest == r_fmt.rt) ||
                                  (result_busy && result_dest == r_fmt.rt));
   assign stall     = fetch.valid && (rs_hazard || rt_hazard);

   assign decoded.valid     = fetch.valid && !stall;
   assign decoded.pc        = fetch.pc;
   assign decoded.alu_op    = alu_op;
   assign decoded.operand_a = read_data_a;
   assign decoded.operand_b = use_imm ? imm : read_data_b;
   assign decoded.reg_write = reg_write;
   assign decoded.dest      = dest;
   assign decoded.is_branch = is_branch;
   assign decoded.is_jal    = is_jal;
   assign decoded.illegal   = illegal;
   assign decoded.imm       = imm;

endmodule

// File: source/execute.sv
// =========================================================================
// execute stage
//   stage register with squash, ALU, BEQZ zero test, JAL link value,
//   redirect generation and busy report for the hazard check
// =========================================================================
`timescale 1ns/1ps
`include "core_config.svh"

module execute (
   input  logic                        clk,
   input  logic                        rst,
   input  pipe_pkg::decode_packet_t    decoded,
   output pipe_pkg::redirect_t         redirect,
   output pipe_pkg::exec_packet_t      executed,
   output logic [`CORE_REG_ADDR_W-1:0] busy_dest,
   output logic                        busy
);

   pipe_pkg::decode_packet_t stage;
   logic [`CORE_DATA_W-1:0]  alu_result;
   logic [`CORE_DATA_W-1:0]  next_pc;

   // the packet arriving with a redirect came from the wrong path
   always_ff @(posedge clk) begin
      stage <= decoded;
      if (rst || redirect.valid) begin
         stage.valid <= 1'b0;
      end
   end

   always_comb begin
      case (stage.alu_op)
         isa_pkg::ALU_ADD: alu_result = stage.operand_a + stage.operand_b;
         isa_pkg::ALU_SUB: alu_result = stage.operand_a - stage.operand_b;
         isa_pkg::ALU_AND: alu_result = stage.operand_a & stage.operand_b;
         isa_pkg::ALU_XOR: alu_result = stage.operand_a ^ stage.operand_b;
         default:          alu_result = stage.operand_b;
      endcase
   end

   assign next_pc = stage.pc + `CORE_DATA_W'd2;

   // BEQZ tests rs, which sits in operand_a
   assign redirect.valid  = stage.valid &&
                            (stage.is_jal || (stage.is_branch && stage.operand_a == '0));
   assign redirect.target = next_pc + stage.imm;

   assign executed.valid     = stage.valid;
   assign executed.pc        = stage.pc;
   assign executed.reg_write = stage.reg_write;
   assign executed.dest      = stage.dest;
   assign executed.data      = stage.is_jal ? next_pc : alu_result;
   assign executed.illegal   = stage.illegal;

   assign busy_dest = stage.dest;
   assign busy      = stage.valid && stage.reg_write;

   // squash leaves a bubble behind, so a redirect never lasts two cycles
   redirect_one_cycle: assert property (@(posedge clk) disable iff (rst)
      redirect.valid |=> !redirect.valid)
      else $error("redirect held longer than one cycle");

endmodule

// File: source/isa_pkg.sv
// =========================================================================
// ISA encoding
//   opcode, ALU operation and R-type function enums
//   instruction field layouts for each format
// =========================================================================
`include "core_config.svh"

package isa_pkg;

   // opcode lives in inst[15:11]
   typedef enum logic [4:0] {
      OP_NOP  = 5'b00001,
      OP_JAL  = 5'b00110,
      OP_ADDI = 5'b01000,
      OP_XORI = 5'b01010,
      OP_BEQZ = 5'b01100,
      OP_LBI  = 5'b11000,
      OP_ALU  = 5'b11011
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   typedef enum logic [1:0] {
      FN_ADD = 2'b00,
      FN_SUB = 2'b01,
      FN_XOR = 2'b10,
      FN_AND = 2'b11
   } funct_e;

   // R-type: rd <= rs op rt
   typedef struct packed {
      opcode_e                     op;
      logic [`CORE_REG_ADDR_W-1:0] rs;
      logic [`CORE_REG_ADDR_W-1:0] rt;
      logic [`CORE_REG_ADDR_W-1:0] rd;
      funct_e                      funct;
   } r_fmt_t;

   // ADDI and XORI, result goes to rt
   typedef struct packed {
      opcode_e                     op;
      logic [`CORE_REG_ADDR_W-1:0] rs;
      logic [`CORE_REG_ADDR_W-1:0] rt;
      logic [4:0]                  imm5;
   } i5_fmt_t;

   // LBI and BEQZ, rs is both source and target
   typedef struct packed {
      opcode_e                     op;
      logic [`CORE_REG_ADDR_W-1:0] rs;
      logic [7:0]                  imm8;
   } i8_fmt_t;

   typedef struct packed {
      opcode_e     op;
      logic [10:0] imm11;
   } j_fmt_t;

endpackage

// File: source/pipe_core.sv
// =========================================================================
// core top level
//   decode, register file, execute and result stages
// =========================================================================
`timescale 1ns/1ps
`include "core_config.svh"

module pipe_core (
   input  logic                    clk,
   input  logic                    rst,
   input  pipe_pkg::fetch_packet_t fetch,
   output logic                    stall,
   output pipe_pkg::redirect_t     redirect,
   output pipe_pkg::retire_t       retire
);

   pipe_pkg::decode_packet_t    decoded;
   pipe_pkg::exec_packet_t      executed;
   logic [`CORE_REG_ADDR_W-1:0] read_addr_a, read_addr_b;
   logic [`CORE_DATA_W-1:0]     read_data_a, read_data_b;
   logic                        write_en;
   logic [`CORE_REG_ADDR_W-1:0] write_addr;
   logic [`CORE_DATA_W-1:0]     write_data;
   logic [`CORE_REG_ADDR_W-1:0] exec_dest, result_dest;
   logic                        exec_busy, result_busy;

   decode decode_stage (
      .fetch       (fetch),
      .exec_dest   (exec_dest),
      .exec_busy   (exec_busy),
      .result_dest (result_dest),
      .result_busy (result_busy),
      .read_addr_a (read_addr_a),
      .read_addr_b (read_addr_b),
      .read_data_a (read_data_a),
      .read_data_b (read_data_b),
      .stall       (stall),
      .decoded     (decoded)
   );

   reg_file regs (
      .clk         (clk),
      .rst         (rst),
      .read_addr_a (read_addr_a),
      .read_addr_b (read_addr_b),
      .read_data_a (read_data_a),
      .read_data_b (read_data_b),
      .write_en    (write_en),
      .write_addr  (write_addr),
      .write_data  (write_data)
   );

   execute execute_stage (
      .clk       (clk),
      .rst       (rst),
      .decoded   (decoded),
      .redirect  (redirect),
      .executed  (executed),
      .busy_dest (exec_dest),
      .busy      (exec_busy)
   );

   result result_stage (
      .clk        (clk),
      .rst        (rst),
      .executed   (executed),
      .retire     (retire),
      .write_en   (write_en),
      .write_addr (write_addr),
      .write_data (write_data),
      .busy_dest  (result_dest),
      .busy       (result_busy)
   );

endmodule

// File: source/pipe_pkg.sv
// =========================================================================
// pipeline transport types
//   fetch packet, decode packet, execute packet, redirect and retire
// =========================================================================
`include "core_config.svh"

package pipe_pkg;

   typedef struct packed {
      logic                     valid;
      logic [`CORE_DATA_W-1:0]  pc;
      logic [`CORE_INST_W-1:0]  inst;
   } fetch_packet_t;

   typedef struct packed {
      logic                        valid;
      logic [`CORE_DATA_W-1:0]     pc;
      isa_pkg::alu_op_e            alu_op;
      logic [`CORE_DATA_W-1:0]     operand_a;
      logic [`CORE_DATA_W-1:0]     operand_b;
      logic                        reg_write;
      logic [`CORE_REG_ADDR_W-1:0] dest;
      logic                        is_branch;
      logic                        is_jal;
      logic                        illegal;
      logic [`CORE_DATA_W-1:0]     imm;
   } decode_packet_t;

   typedef struct packed {
      logic                        valid;
      logic [`CORE_DATA_W-1:0]     pc;
      logic                        reg_write;
      logic [`CORE_REG_ADDR_W-1:0] dest;
      logic [`CORE_DATA_W-1:0]     data;
      logic                        illegal;
   } exec_packet_t;

   typedef struct packed {
      logic                    valid;
      logic [`CORE_DATA_W-1:0] target;
   } redirect_t;

   // retire record is the registered execute packet
   typedef exec_packet_t retire_t;

endpackage

// File: source/reg_file.sv
// =========================================================================
// register file
//   eight 16-bit registers, two asynchronous read ports,
//   one write port taken at the clock edge
// =========================================================================
`timescale 1ns/1ps
`include "core_config.svh"

module reg_file (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [`CORE_REG_ADDR_W-1:0] read_addr_a,
   input  logic [`CORE_REG_ADDR_W-1:0] read_addr_b,
   output logic [`CORE_DATA_W-1:0]     read_data_a,
   output logic [`CORE_DATA_W-1:0]     read_data_b,
   input  logic                        write_en,
   input  logic [`CORE_REG_ADDR_W-1:0] write_addr,
   input  logic [`CORE_DATA_W-1:0]     write_data
);

   localparam int NUM_REGS = 1 << `CORE_REG_ADDR_W;

   logic [`CORE_DATA_W-1:0] regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (write_en) begin
         regs[write_addr] <= write_data;
      end
   end

   // no bypass, decode stalls until the write has landed
   assign read_data_a = regs[read_addr_a];
   assign read_data_b = regs[read_addr_b];

   write_addr_known: assert property (@(posedge clk) disable iff (rst)
      write_en |-> !$isunknown(write_addr))
      else $error("register write with unknown address");

endmodule

// File: source/result.sv
// =========================================================================
// result stage
//   retire register, register-file write gating and busy report
// =========================================================================
`timescale 1ns/1ps
`include "core_config.svh"

module result (
   input  logic                        clk,
   input  logic                        rst,
   input  pipe_pkg::exec_packet_t      executed,
   output pipe_pkg::retire_t           retire,
   output logic                        write_en,
   output logic [`CORE_REG_ADDR_W-1:0] write_addr,
   output logic [`CORE_DATA_W-1:0]     write_data,
   output logic [`CORE_REG_ADDR_W-1:0] busy_dest,
   output logic                        busy
);

   always_ff @(posedge clk) begin
      retire <= executed;
      if (rst) begin
         retire.valid <= 1'b0;
      end
   end

   // an illegal instruction retires but never writes
   assign write_en   = retire.valid && retire.reg_write && !retire.illegal;
   assign write_addr = retire.dest;
   assign write_data = retire.data;

   assign busy_dest = retire.dest;
   assign busy      = retire.valid && retire.reg_write;

endmodule

// File: testbench/tb_pipe_core.sv
// =========================================================================
// testbench for the core
//   clock and reset, directed and random instruction stimulus,
//   shadow register file and queue of accepted instructions,
//   assertions on retire, redirect and the reset state, timeout
// =========================================================================
`timescale 1ns/1ps
`include "core_config.svh"

module tb_pipe_core;

   localparam int NUM_RANDOM  = 24;
   localparam int TOTAL_INSTS = 8 + NUM_RANDOM + 4 + 9 + 10;
   localparam int CYCLE_LIMIT = 4 * TOTAL_INSTS + 50;

   logic                    clk;
   logic                    rst;
   pipe_pkg::fetch_packet_t fetch;
   logic                    stall;
   pipe_pkg::redirect_t     redirect;
   pipe_pkg::retire_t       retire;

   logic [`CORE_DATA_W-1:0] shadow [8];
   pipe_pkg::retire_t       inflight [$];
   pipe_pkg::retire_t       accept_rec, exp_s1, exp_s2;
   logic                    accept_taken, redir_s1;
   logic [`CORE_DATA_W-1:0] accept_target, target_s1;
   logic [`CORE_DATA_W-1:0] pc;
   logic                    quiet_check;
   logic                    last_stalled, last_dropped;
   int                      last_accept_cycle;
   int                      cycle_count;
   int                      seed;
   int                      errors, tests_run, tests_failed, test_start_errors;

   pipe_core uut (
      .clk      (clk),
      .rst      (rst),
      .fetch    (fetch),
      .stall    (stall),
      .redirect (redirect),
      .retire   (retire)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_error(input string msg);
      errors++;
      $display("** Error at %0t ns: %s", $time, msg);
   endtask

   function automatic logic [15:0] alu_inst(input logic [1:0] fn, input logic [2:0] rd,
                                            input logic [2:0] rs, input logic [2:0] rt);
      return {isa_pkg::OP_ALU, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] imm5_inst(input logic [4:0] op, input logic [2:0] rt,
                                             input logic [2:0] rs, input logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [15:0] imm8_inst(input logic [4:0] op, input logic [2:0] rs,
                                             input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] jal_inst(input logic [10:0] imm);
      return {isa_pkg::OP_JAL, imm};
   endfunction

   // ISA rules applied to the shadow register file
   task automatic predict(input logic [15:0] inst, input logic [15:0] at_pc,
                          output pipe_pkg::retire_t rec, output logic taken,
                          output logic [15:0] target);
      logic [15:0] a;
      logic [15:0] b;
      a = shadow[inst[10:8]];
      b = shadow[inst[7:5]];
      rec = '0;
      rec.valid = 1'b1;
      rec.pc = at_pc;
      taken = 1'b0;
      target = '0;
      case (inst[15:11])
         isa_pkg::OP_ALU: begin
            rec.reg_write = 1'b1;
            rec.dest = inst[4:2];
            case (inst[1:0])
               isa_pkg::FN_ADD: rec.data = a + b;
               isa_pkg::FN_SUB: rec.data = a - b;
               isa_pkg::FN_XOR: rec.data = a ^ b;
               default:         rec.data = a & b;
            endcase
         end
         isa_pkg::OP_ADDI: begin
            rec.reg_write = 1'b1;
            rec.dest = inst[7:5];
            rec.data = a + {{11{inst[4]}}, inst[4:0]};
         end
         isa_pkg::OP_XORI: begin
            rec.reg_write = 1'b1;
            rec.dest = inst[7:5];
            rec.data = a ^ {11'b0, inst[4:0]};
         end
         isa_pkg::OP_LBI: begin
            rec.reg_write = 1'b1;
            rec.dest = inst[10:8];
            rec.data = {{8{inst[7]}}, inst[7:0]};
         end
         isa_pkg::OP_BEQZ: begin
            taken = (a == 16'h0000);
            target = at_pc + 16'd2 + {{8{inst[7]}}, inst[7:0]};
         end
         isa_pkg::OP_JAL: begin
            rec.reg_write = 1'b1;
            rec.dest = 3'd7;
            rec.data = at_pc + 16'd2;
            taken = 1'b1;
            target = at_pc + 16'd2 + {{5{inst[10]}}, inst[10:0]};
         end
         isa_pkg::OP_NOP: ;
         default: rec.illegal = 1'b1;
      endcase
   endtask

   // present one packet and hold it until the core takes it
   task automatic send(input logic [15:0] inst);
      pipe_pkg::retire_t rec;
      logic              taken;
      logic [15:0]       target;
      logic              done;
      fetch.valid <= 1'b1;
      fetch.pc <= pc;
      fetch.inst <= inst;
      last_stalled = 1'b0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (stall) begin
            last_stalled = 1'b1;
         end else begin
            done = 1'b1;
            // a packet taken while redirecting is wrong path and dropped
            last_dropped = redirect.valid;
            if (!redirect.valid) begin
               predict(inst, pc, rec, taken, target);
               inflight.push_back(rec);
               accept_rec = rec;
               accept_taken = taken;
               accept_target = target;
               last_accept_cycle = cycle_count;
            end
         end
         @(posedge clk);
      end
      pc = pc + 16'd2;
   endtask

   task automatic drain();
      fetch.valid <= 1'b0;
      repeat (4) @(posedge clk);
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != test_start_errors)
         tests_failed++;
      $display("test %s finished with %0d errors", name, errors - test_start_errors);
      test_start_errors = errors;
   endtask

   // expected retire two edges after acceptance, redirect one edge after
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (rst) begin
         exp_s1 <= '0;
         exp_s2 <= '0;
         redir_s1 <= 1'b0;
         target_s1 <= '0;
      end else begin
         exp_s1 <= accept_rec;
         exp_s2 <= exp_s1;
         redir_s1 <= accept_taken;
         target_s1 <= accept_target;
      end
      accept_rec <= '0;
      accept_taken <= 1'b0;
   end

   always @(negedge clk) begin
      pipe_pkg::retire_t rec;
      if (!rst && retire.valid && inflight.size() > 0) begin
         rec = inflight.pop_front();
         if (rec.reg_write && !rec.illegal)
            shadow[rec.dest] = rec.data;
      end
   end

   always @(posedge clk) begin
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
         $display("Regression failed");
         $finish;
      end
   end

   quiet_after_reset: assert property (@(posedge clk)
      quiet_check |-> (!stall && !redirect.valid && !retire.valid))
      else report_error("stall, redirect or retire active around reset");

   retire_matches_model: assert property (@(posedge clk) disable iff (rst)
      retire.valid == exp_s2.valid &&
      (!exp_s2.valid || (retire.pc == exp_s2.pc && retire.illegal == exp_s2.illegal &&
       retire.reg_write == exp_s2.reg_write &&
       (!exp_s2.reg_write || (retire.dest == exp_s2.dest && retire.data == exp_s2.data)))))
      else report_error("retire record differs from the model");

   redirect_matches_model: assert property (@(posedge clk) disable iff (rst)
      redirect.valid == redir_s1 && (!redir_s1 || redirect.target == target_s1))
      else report_error("redirect differs from the model");

   initial begin
      int          p;
      int          kind;
      logic [31:0] word;
      rst = 1'b1;
      fetch = '0;
      quiet_check = 1'b0;
      pc = 16'h0100;
      seed = 48;
      cycle_count = 0;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      test_start_errors = 0;
      accept_rec = '0;
      accept_taken = 1'b0;
      accept_target = '0;
      last_dropped = 1'b0;
      for (int i = 0; i < 8; i++) begin
         shadow[i] = '0;
      end

      @(posedge clk);
      quiet_check <= 1'b1;
      @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      quiet_check <= 1'b0;
      @(posedge clk);
      finish_test("reset");

      // seed every register before the random arithmetic
      for (int i = 0; i < 8; i++) begin
         word = $random(seed);
         send(imm8_inst(isa_pkg::OP_LBI, i[2:0], word[7:0]));
      end
      for (int i = 0; i < NUM_RANDOM; i++) begin
         word = $random(seed);
         kind = word[31:16] % 7;
         case (kind)
            0: send(alu_inst(isa_pkg::FN_ADD, word[8:6], word[2:0], word[5:3]));
            1: send(alu_inst(isa_pkg::FN_SUB, word[8:6], word[2:0], word[5:3]));
            2: send(alu_inst(isa_pkg::FN_AND, word[8:6], word[2:0], word[5:3]));
            3: send(alu_inst(isa_pkg::FN_XOR, word[8:6], word[2:0], word[5:3]));
            4: send(imm5_inst(isa_pkg::OP_ADDI, word[5:3], word[2:0], word[12:8]));
            5: send(imm5_inst(isa_pkg::OP_XORI, word[5:3], word[2:0], word[12:8]));
            default: send(imm8_inst(isa_pkg::OP_LBI, word[2:0], word[15:8]));
         endcase
      end
      drain();
      finish_test("arithmetic");

      // each instruction reads the one before it
      send(imm8_inst(isa_pkg::OP_LBI, 3'd2, 8'h35));
      p = last_accept_cycle;
      send(alu_inst(isa_pkg::FN_ADD, 3'd3, 3'd2, 3'd2));
      assert (last_stalled && last_accept_cycle - p >= 3)
         else report_error("ADD was accepted before LBI left result");
      p = last_accept_cycle;
      send(imm5_inst(isa_pkg::OP_XORI, 3'd4, 3'd3, 5'h1b));
      assert (last_stalled && last_accept_cycle - p >= 3)
         else report_error("XORI was accepted before ADD left result");
      p = last_accept_cycle;
      send(alu_inst(isa_pkg::FN_SUB, 3'd5, 3'd4, 3'd3));
      assert (last_stalled && last_accept_cycle - p >= 3)
         else report_error("SUB was accepted before XORI left result");
      drain();
      finish_test("hazards");

      send(imm8_inst(isa_pkg::OP_LBI, 3'd1, 8'h00));
      send(imm8_inst(isa_pkg::OP_BEQZ, 3'd1, 8'hf0));
      send(imm5_inst(isa_pkg::OP_ADDI, 3'd6, 3'd6, 5'h01));
      assert (last_dropped)
         else report_error("packet after a taken BEQZ was not dropped");
      send(jal_inst(11'h123));
      send(imm5_inst(isa_pkg::OP_ADDI, 3'd6, 3'd6, 5'h01));
      assert (last_dropped)
         else report_error("packet after a JAL was not dropped");
      // read back the link register
      send(imm5_inst(isa_pkg::OP_XORI, 3'd7, 3'd7, 5'h00));
      send(imm8_inst(isa_pkg::OP_LBI, 3'd2, 8'h09));
      send(imm8_inst(isa_pkg::OP_BEQZ, 3'd2, 8'h10));
      send({isa_pkg::OP_NOP, 11'h000});
      assert (!last_dropped)
         else report_error("packet after an untaken BEQZ was dropped");
      drain();
      finish_test("control flow");

      send({5'b11111, 11'h7ff});
      send({5'b00000, 11'h2a5});
      for (int i = 0; i < 8; i++) begin
         send(imm5_inst(isa_pkg::OP_XORI, i[2:0], i[2:0], 5'h00));
      end
      drain();
      assert (inflight.size() == 0)
         else report_error("accepted instructions never retired");
      finish_test("illegal opcodes");

      $display("tests run %0d, tests with errors %0d, total errors %0d",
               tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule
